// File: compile.f
verilog/rv32i_types.sv
verilog/physical_regfile.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/ldst_unit.sv
verilog/exec_cluster.sv
verif/wb_mem_model.sv
verif/tb_exec_cluster.sv

// File: run.sh
#!/bin/sh
# build and run the execution cluster testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_exec_cluster -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verif/tb_exec_cluster.sv
module tb_exec_cluster;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_types::*;

    // one expected writeback from the alu or mul lane
    typedef struct packed {
        preg_t       tag;
        word_t       value;
        logic [31:0] issue_edge;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        alu_issue_valid, alu_use_imm;
    alu_op_t     alu_op;
    preg_t       alu_rs1_s, alu_rs2_s, alu_rd_s;
    word_t       alu_imm;
    logic        mul_issue_valid;
    mul_op_t     mul_op;
    preg_t       mul_rs1_s, mul_rs2_s, mul_rd_s;
    logic        ldst_issue_valid, ldst_ready;
    mem_op_t     ldst_op;
    preg_t       ldst_rs1_s, ldst_rs2_s, ldst_rd_s;
    word_t       ldst_imm;
    logic        ctx_load;
    word_t       ctx_data [NUM_ARCH_REGS];
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [29:0] wb_adr;
    logic [3:0]  wb_sel;
    word_t       wb_dat_w, wb_dat_r;
    logic        alu_wb_valid, mul_wb_valid, ld_wb_valid, st_done;
    preg_t       alu_wb_tag, mul_wb_tag, ld_wb_tag;
    word_t       alu_wb_value, mul_wb_value, ld_wb_value;
    word_t       reg_data [NUM_REGS];

    // reference model state
    int          seed = 32'h3fe63be4;
    word_t       model_regs [NUM_REGS];
    word_t       shadow_mem [256];
    logic        busy [NUM_REGS];
    preg_t       release_q [$];
    expect_t     alu_q [$];
    expect_t     mul_q [$];
    logic        mem_pending, mem_is_store, got_result;
    preg_t       mem_tag;
    word_t       mem_value;
    logic [31:0] cyc_cnt = '0;
    int          value_errors = 0;
    int          other_errors = 0;
    string       test_name;

    exec_cluster #(.num_regs(NUM_REGS)) u_exec_cluster (.*);

    wb_mem_model #(.depth(256), .wait_seed(32'h3fe63be4)) u_mem (
        .clk, .rst, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_w(wb_dat_w), .sel(wb_sel), .dat_r(wb_dat_r), .ack(wb_ack)
    );

    always #50 clk = ~clk;
    // edge counter, read 1 ns after each edge
    always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // random tag that no op in flight will write
    function automatic preg_t pick_free();
        preg_t t;
        for (int i = 0; i < 100; i++) begin
            t = preg_t'(rand_below(NUM_REGS));
            if (!busy[t]) return t;
        end
        return '0;
    endfunction

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // widen as the op says, keep 64 bits of product
    function automatic word_t mul_ref(input mul_op_t op, input word_t a, input word_t b);
        logic [63:0] a64, b64, p;
        a64 = (op == MUL_MULH || op == MUL_MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
        b64 = (op == MUL_MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        p   = a64 * b64;
        return (op == MUL_MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %08h actual %08h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_tag(input string name, input preg_t exp, input preg_t act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %s expected %0d edges actual %0d edges", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_mem(input string name, input int addr, input word_t exp,
                             input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s mem[%03h] expected %08h actual %08h", name, addr, exp, act);
            value_errors++;
        end
    endtask

    // model takes the value, tag frees after the write edge
    task automatic retire(input preg_t tag, input word_t value);
        if (tag != '0) begin
            model_regs[tag] = value;
            release_q.push_back(tag);
        end
    endtask

    task automatic score_result(input string lane, input expect_t e, input preg_t tag,
                                input word_t value, input int latency);
        check_tag({test_name, " ", lane, " tag"}, e.tag, tag);
        check_word({test_name, " ", lane, " value"}, e.value, value);
        check_latency({test_name, " ", lane, " latency"}, latency,
                      int'(cyc_cnt - e.issue_edge) + 1);
        retire(e.tag, e.value);
    endtask

    // sample the broadcasts 1 ns after an edge
    task automatic observe_results();
        got_result = 1'b0;
        while (release_q.size() > 0) busy[release_q.pop_front()] = 1'b0;
        check_word({test_name, " zero register"}, '0, reg_data[0]);
        if (alu_wb_valid && alu_q.size() == 0) begin
            $display("%s: alu wrote back with nothing issued", test_name);
            other_errors++;
        end else if (alu_wb_valid) begin
            score_result("alu", alu_q.pop_front(), alu_wb_tag, alu_wb_value, 2);
            got_result = 1'b1;
        end
        if (mul_wb_valid && mul_q.size() == 0) begin
            $display("%s: multiplier wrote back with nothing issued", test_name);
            other_errors++;
        end else if (mul_wb_valid) begin
            score_result("mul", mul_q.pop_front(), mul_wb_tag, mul_wb_value, 3);
            got_result = 1'b1;
        end
        if ((ld_wb_valid || st_done) && !mem_pending) begin
            $display("%s: load/store completed with nothing issued", test_name);
            other_errors++;
        end else if (ld_wb_valid || st_done) begin
            check_bit({test_name, " st_done"}, mem_is_store, st_done);
            check_bit({test_name, " ld_wb_valid"}, !mem_is_store, ld_wb_valid);
            if (!mem_is_store) begin
                check_tag({test_name, " load tag"}, mem_tag, ld_wb_tag);
                check_word({test_name, " load value"}, mem_value, ld_wb_value);
                retire(mem_tag, mem_value);
            end
            mem_pending = 1'b0;
            got_result  = 1'b1;
        end
        check_bit({test_name, " ldst_ready"}, !mem_pending, ldst_ready);
    endtask

    task automatic issue_alu();
        expect_t e;
        word_t   b;
        alu_op      = alu_op_t'(rand_below(10));
        alu_rs1_s   = pick_free();
        alu_rs2_s   = pick_free();
        alu_use_imm = (rand_below(2) == 1);
        alu_imm     = $random(seed);
        // now and then aim at the zero register
        alu_rd_s    = (rand_below(16) == 0) ? '0 : pick_free();
        busy[alu_rd_s] = (alu_rd_s != '0);
        b = alu_use_imm ? alu_imm : model_regs[alu_rs2_s];
        e.tag        = alu_rd_s;
        e.value      = alu_ref(alu_op, model_regs[alu_rs1_s], b);
        e.issue_edge = cyc_cnt + 1;
        alu_q.push_back(e);
        alu_issue_valid = 1'b1;
    endtask

    task automatic issue_mul();
        expect_t e;
        mul_op    = mul_op_t'(rand_below(4));
        mul_rs1_s = pick_free();
        mul_rs2_s = pick_free();
        mul_rd_s  = pick_free();
        busy[mul_rd_s] = (mul_rd_s != '0);
        e.tag        = mul_rd_s;
        e.value      = mul_ref(mul_op, model_regs[mul_rs1_s], model_regs[mul_rs2_s]);
        e.issue_edge = cyc_cnt + 1;
        mul_q.push_back(e);
        mul_issue_valid = 1'b1;
    endtask

    // immediate is picked so base plus offset lands inside the 1 KB memory
    task automatic issue_mem();
        int         target;
        int         word_idx;
        int         lane;
        logic [7:0] byte_v;
        ldst_op = mem_op_t'(rand_below(5));
        target  = rand_below(1024);
        if (ldst_op == MEM_LW || ldst_op == MEM_SW) target = target & ~3;
        word_idx   = target / 4;
        lane       = target % 4;
        ldst_rs1_s = pick_free();
        ldst_rs2_s = pick_free();
        ldst_imm   = word_t'(target) - model_regs[ldst_rs1_s];
        byte_v     = shadow_mem[word_idx][8*lane +: 8];
        mem_is_store = (ldst_op == MEM_SW) || (ldst_op == MEM_SB);
        ldst_rd_s  = mem_is_store ? '0 : pick_free();
        busy[ldst_rd_s] = (ldst_rd_s != '0);
        mem_tag    = ldst_rd_s;
        case (ldst_op)
            MEM_SW:  shadow_mem[word_idx] = model_regs[ldst_rs2_s];
            MEM_SB:  shadow_mem[word_idx][8*lane +: 8] = model_regs[ldst_rs2_s][7:0];
            MEM_LB:  mem_value = {{24{byte_v[7]}}, byte_v};
            MEM_LBU: mem_value = {24'd0, byte_v};
            default: mem_value = shadow_mem[word_idx];
        endcase
        mem_pending      = 1'b1;
        ldst_issue_valid = 1'b1;
    endtask

    // issue on every lane each cycle until done, then drain
    task automatic run_traffic(input string name, input int n_alu, input int n_mul,
                               input int n_mem);
        int idle;
        test_name = name;
        idle      = 0;
        while (n_alu > 0 || n_mul > 0 || n_mem > 0 || alu_q.size() > 0 ||
               mul_q.size() > 0 || mem_pending) begin
            @(posedge clk);
            #1;
            observe_results();
            alu_issue_valid  = 1'b0;
            mul_issue_valid  = 1'b0;
            ldst_issue_valid = 1'b0;
            if (n_alu > 0) begin
                issue_alu();
                n_alu--;
                got_result = 1'b1;
            end
            if (n_mul > 0) begin
                issue_mul();
                n_mul--;
                got_result = 1'b1;
            end
            if (n_mem > 0 && !mem_pending && ldst_ready) begin
                issue_mem();
                n_mem--;
                got_result = 1'b1;
            end
            idle = got_result ? 0 : idle + 1;
            if (idle >= 50) begin
                $display("%s: no writeback or completion for 50 cycles", name);
                other_errors++;
                break;
            end
        end
        alu_issue_valid  = 1'b0;
        mul_issue_valid  = 1'b0;
        ldst_issue_valid = 1'b0;
        @(posedge clk);
        #1;
        alu_q.delete();
        mul_q.delete();
        release_q.delete();
        mem_pending = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) busy[i] = 1'b0;
    endtask

    task automatic compare_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            check_word($sformatf("%s reg %0d", test_name, i), model_regs[i], reg_data[i]);
        end
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 256; i++) begin
            check_mem(test_name, i * 4, shadow_mem[i], u_mem.mem[i]);
        end
    endtask

    // thread swap, register 0 keeps reading zero
    task automatic context_swap();
        test_name = "context load";
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_ARCH_REGS; i++) ctx_data[i] = $random(seed);
        ctx_load = 1'b1;
        @(posedge clk);
        #1;
        ctx_load = 1'b0;
        for (int i = 1; i < NUM_ARCH_REGS; i++) model_regs[i] = ctx_data[i];
        compare_regs();
    endtask

    initial begin
        rst              = 1'b1;
        alu_issue_valid  = 1'b0;
        alu_op           = ALU_ADD;
        alu_rs1_s        = '0;
        alu_rs2_s        = '0;
        alu_rd_s         = '0;
        alu_use_imm      = 1'b0;
        alu_imm          = '0;
        mul_issue_valid  = 1'b0;
        mul_op           = MUL_MUL;
        mul_rs1_s        = '0;
        mul_rs2_s        = '0;
        mul_rd_s         = '0;
        ldst_issue_valid = 1'b0;
        ldst_op          = MEM_LW;
        ldst_rs1_s       = '0;
        ldst_rs2_s       = '0;
        ldst_rd_s        = '0;
        ldst_imm         = '0;
        ctx_load         = 1'b0;
        mem_pending      = 1'b0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) ctx_data[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // state straight out of reset
        test_name = "reset";
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
            busy[i]       = 1'b0;
        end
        compare_regs();
        check_bit("reset ldst_ready", 1'b1, ldst_ready);
        check_bit("reset alu_wb_valid", 1'b0, alu_wb_valid);
        check_bit("reset mul_wb_valid", 1'b0, mul_wb_valid);
        check_bit("reset ld_wb_valid", 1'b0, ld_wb_valid);
        check_bit("reset st_done", 1'b0, st_done);
        check_bit("reset wb_cyc", 1'b0, wb_cyc);
        check_bit("reset wb_stb", 1'b0, wb_stb);
        check_bit("reset wb_we", 1'b0, wb_we);
        // shadow starts from the memory image
        for (int i = 0; i < 256; i++) shadow_mem[i] = u_mem.mem[i];

        run_traffic("alu random", 300, 0, 0);
        compare_regs();
        run_traffic("mul back to back", 0, 200, 0);
        compare_regs();
        run_traffic("load store", 0, 0, 80);
        compare_regs();
        compare_memory();
        run_traffic("mixed lanes", 150, 150, 40);
        compare_regs();
        compare_memory();
        context_swap();
        run_traffic("after context load", 60, 60, 20);
        compare_regs();
        compare_memory();

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_exec_cluster

// File: verif/wb_mem_model.sv
module wb_mem_model #(
    parameter int          depth     = 256,
    parameter int unsigned wait_seed = 32'h1
) (
    input  logic               clk,
    input  logic               rst,
    // wishbone classic slave side
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [29:0]        adr,
    input  rv32i_types::word_t dat_w,
    input  logic [3:0]         sel,
    output rv32i_types::word_t dat_r,
    output logic               ack
);
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_types::*;

    word_t mem [depth];
    int    seed;
    int    wait_left;
    logic  armed;
    int    idx;

    // fill mixes every address bit into the word
    initial begin
        seed      = wait_seed;
        ack       = 1'b0;
        dat_r     = '0;
        armed     = 1'b0;
        wait_left = 0;
        for (int i = 0; i < depth; i++) begin
            mem[i] = word_t'(i) * 32'h9e3779b1 + 32'h6a09e667;
        end
    end

    always @(posedge clk) begin
        ack <= 1'b0;
        if (rst) begin
            armed = 1'b0;
        end else if (cyc && stb && !ack) begin
            // draw 0 to 3 wait cycles once per transfer
            if (!armed) begin
                wait_left = int'($unsigned($random(seed)) % 4);
                armed     = 1'b1;
            end
            if (wait_left == 0) begin
                idx = int'(adr) % depth;
                if (we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel[b]) begin
                            mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
                        end
                    end
                end
                dat_r <= mem[idx];
                ack   <= 1'b1;
                armed  = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

endmodule : wb_mem_model

// File: verilog/alu_unit.sv
module alu_unit (
    input  logic                 clk,
    input  logic                 rst,
    // issue group
    input  logic                 issue_valid,
    input  rv32i_types::alu_op_t op,
    input  rv32i_types::preg_t   rd_s,
    input  logic                 use_imm,
    input  rv32i_types::word_t   imm,
    // operands, one cycle after issue
    input  rv32i_types::word_t   rs1_v,
    input  rv32i_types::word_t   rs2_v,
    // writeback and broadcast
    output logic                 wb_valid,
    output rv32i_types::preg_t   wb_tag,
    output rv32i_types::word_t   wb_value
);
    import rv32i_types::*;

    // read stage, waits for the regfile
    logic       s1_valid;
    preg_t      s1_tag;
    alu_op_t    s1_op;
    logic       s1_use_imm;
    word_t      s1_imm;
    // execute
    word_t      opb;
    logic [4:0] shamt;
    word_t      result;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            wb_valid <= s1_valid;
        end
        s1_tag     <= rd_s;
        s1_op      <= op;
        s1_use_imm <= use_imm;
        s1_imm     <= imm;
        wb_tag     <= s1_tag;
        wb_value   <= result;
    end

    assign opb   = s1_use_imm ? s1_imm : rs2_v;
    // shifts only look at the low five bits
    assign shamt = opb[4:0];

    always_comb begin
        case (s1_op)
            ALU_ADD:  result = rs1_v + opb;
            ALU_SUB:  result = rs1_v - opb;
            ALU_AND:  result = rs1_v & opb;
            ALU_OR:   result = rs1_v | opb;
            ALU_XOR:  result = rs1_v ^ opb;
            ALU_SLL:  result = rs1_v << shamt;
            ALU_SRL:  result = rs1_v >> shamt;
            ALU_SRA:  result = word_t'($signed(rs1_v) >>> shamt);
            ALU_SLT:  result = {31'd0, $signed(rs1_v) < $signed(opb)};
            ALU_SLTU: result = {31'd0, rs1_v < opb};
            default:  result = '0;
        endcase
    end

endmodule : alu_unit

// File: verilog/exec_cluster.sv
module exec_cluster #(
    parameter int num_regs = rv32i_types::NUM_REGS
) (
    input  logic                 clk,
    input  logic                 rst,
    // alu issue
    input  logic                 alu_issue_valid,
    input  rv32i_types::alu_op_t alu_op,
    input  rv32i_types::preg_t   alu_rs1_s,
    input  rv32i_types::preg_t   alu_rs2_s,
    input  rv32i_types::preg_t   alu_rd_s,
    input  logic                 alu_use_imm,
    input  rv32i_types::word_t   alu_imm,
    // mul issue
    input  logic                 mul_issue_valid,
    input  rv32i_types::mul_op_t mul_op,
    input  rv32i_types::preg_t   mul_rs1_s,
    input  rv32i_types::preg_t   mul_rs2_s,
    input  rv32i_types::preg_t   mul_rd_s,
    // load/store issue
    input  logic                 ldst_issue_valid,
    input  rv32i_types::mem_op_t ldst_op,
    input  rv32i_types::preg_t   ldst_rs1_s,
    input  rv32i_types::preg_t   ldst_rs2_s,
    input  rv32i_types::preg_t   ldst_rd_s,
    input  rv32i_types::word_t   ldst_imm,
    output logic                 ldst_ready,
    // thread context swap
    input  logic                 ctx_load,
    input  rv32i_types::word_t   ctx_data [rv32i_types::NUM_ARCH_REGS],
    // data memory, wishbone classic
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [29:0]          wb_adr,
    output rv32i_types::word_t   wb_dat_w,
    output logic [3:0]           wb_sel,
    input  rv32i_types::word_t   wb_dat_r,
    input  logic                 wb_ack,
    // result broadcast
    output logic                 alu_wb_valid,
    output rv32i_types::preg_t   alu_wb_tag,
    output rv32i_types::word_t   alu_wb_value,
    output logic                 mul_wb_valid,
    output rv32i_types::preg_t   mul_wb_tag,
    output rv32i_types::word_t   mul_wb_value,
    output logic                 ld_wb_valid,
    output rv32i_types::preg_t   ld_wb_tag,
    output rv32i_types::word_t   ld_wb_value,
    output logic                 st_done,
    output rv32i_types::word_t   reg_data [num_regs]
);
    import rv32i_types::*;

    // operand values from the registered read ports
    word_t alu_rs1_v, alu_rs2_v;
    word_t mul_rs1_v, mul_rs2_v;
    word_t ldst_rs1_v, ldst_rs2_v;

    // broadcast doubles as the regfile write port
    physical_regfile #(.num_regs(num_regs)) u_regfile (
        .clk, .rst, .ctx_load, .ctx_data,
        .alu_rs1_s, .alu_rs2_s, .mul_rs1_s, .mul_rs2_s, .ldst_rs1_s, .ldst_rs2_s,
        .alu_we(alu_wb_valid), .mul_we(mul_wb_valid), .ld_we(ld_wb_valid),
        .alu_rd_s(alu_wb_tag), .mul_rd_s(mul_wb_tag), .ld_rd_s(ld_wb_tag),
        .alu_rd_v(alu_wb_value), .mul_rd_v(mul_wb_value), .ld_rd_v(ld_wb_value),
        .alu_rs1_v, .alu_rs2_v, .mul_rs1_v, .mul_rs2_v, .ldst_rs1_v, .ldst_rs2_v,
        .reg_data
    );

    alu_unit u_alu (
        .clk, .rst, .issue_valid(alu_issue_valid), .op(alu_op), .rd_s(alu_rd_s),
        .use_imm(alu_use_imm), .imm(alu_imm), .rs1_v(alu_rs1_v), .rs2_v(alu_rs2_v),
        .wb_valid(alu_wb_valid), .wb_tag(alu_wb_tag), .wb_value(alu_wb_value)
    );

    mul_unit u_mul (
        .clk, .rst, .issue_valid(mul_issue_valid), .op(mul_op), .rd_s(mul_rd_s),
        .rs1_v(mul_rs1_v), .rs2_v(mul_rs2_v),
        .wb_valid(mul_wb_valid), .wb_tag(mul_wb_tag), .wb_value(mul_wb_value)
    );

    ldst_unit u_ldst (
        .clk, .rst, .issue_valid(ldst_issue_valid), .op(ldst_op), .rd_s(ldst_rd_s),
        .imm(ldst_imm), .ldst_ready, .rs1_v(ldst_rs1_v), .rs2_v(ldst_rs2_v),
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack,
        .ld_wb_valid, .ld_wb_tag, .ld_wb_value, .st_done
    );

endmodule : exec_cluster

// File: verilog/ldst_unit.sv
module ldst_unit (
    input  logic                 clk,
    input  logic                 rst,
    // issue group
    input  logic                 issue_valid,
    input  rv32i_types::mem_op_t op,
    input  rv32i_types::preg_t   rd_s,
    input  rv32i_types::word_t   imm,
    output logic                 ldst_ready,
    // base and store data, one cycle after issue
    input  rv32i_types::word_t   rs1_v,
    input  rv32i_types::word_t   rs2_v,
    // wishbone classic master
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [29:0]          wb_adr,
    output rv32i_types::word_t   wb_dat_w,
    output logic [3:0]           wb_sel,
    input  rv32i_types::word_t   wb_dat_r,
    input  logic                 wb_ack,
    // completion
    output logic                 ld_wb_valid,
    output rv32i_types::preg_t   ld_wb_tag,
    output rv32i_types::word_t   ld_wb_value,
    output logic                 st_done
);
    import rv32i_types::*;

    typedef enum logic [1:0] {ST_IDLE, ST_OPND, ST_BUS} state_t;

    state_t     state;
    mem_op_t    op_r;
    word_t      imm_r;
    logic [1:0] byte_off;
    word_t      addr;
    logic       is_store;
    logic [7:0] ld_byte;
    word_t      load_value;

    assign ldst_ready = (state == ST_IDLE);
    assign addr       = rs1_v + imm_r;
    assign is_store   = (op_r == MEM_SW) || (op_r == MEM_SB);

    // pick the addressed byte, then extend
    always_comb begin
        ld_byte = wb_dat_r[8*byte_off +: 8];
        case (op_r)
            MEM_LB:  load_value = {{24{ld_byte[7]}}, ld_byte};
            MEM_LBU: load_value = {24'd0, ld_byte};
            default: load_value = wb_dat_r;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            wb_cyc      <= 1'b0;
            wb_stb      <= 1'b0;
            wb_we       <= 1'b0;
            ld_wb_valid <= 1'b0;
            st_done     <= 1'b0;
        end else begin
            // completion flags are single-cycle pulses
            ld_wb_valid <= 1'b0;
            st_done     <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (issue_valid) begin
                        op_r      <= op;
                        imm_r     <= imm;
                        ld_wb_tag <= rd_s;
                        state     <= ST_OPND;
                    end
                end
                ST_OPND: begin
                    // operands are here, start the transfer
                    wb_cyc   <= 1'b1;
                    wb_stb   <= 1'b1;
                    wb_we    <= is_store;
                    wb_adr   <= addr[31:2];
                    byte_off <= addr[1:0];
                    wb_sel   <= (op_r == MEM_SB) ? (4'b0001 << addr[1:0]) : 4'hf;
                    wb_dat_w <= (op_r == MEM_SB) ? {4{rs2_v[7:0]}} : rs2_v;
                    state    <= ST_BUS;
                end
                ST_BUS: begin
                    if (wb_ack) begin
                        wb_cyc      <= 1'b0;
                        wb_stb      <= 1'b0;
                        wb_we       <= 1'b0;
                        ld_wb_valid <= !is_store;
                        st_done     <= is_store;
                        ld_wb_value <= load_value;
                        state       <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // one access at a time, scheduler must watch ldst_ready
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> ldst_ready)
        else $error("load/store issue while busy");

    // request and address hold until the slave acks
    a_cyc_until_ack: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr))
        else $error("wishbone cycle dropped before ack");

endmodule : ldst_unit

// File: verilog/mul_unit.sv
module mul_unit (
    input  logic                 clk,
    input  logic                 rst,
    // issue group
    input  logic                 issue_valid,
    input  rv32i_types::mul_op_t op,
    input  rv32i_types::preg_t   rd_s,
    // operands, one cycle after issue
    input  rv32i_types::word_t   rs1_v,
    input  rv32i_types::word_t   rs2_v,
    // writeback and broadcast
    output logic                 wb_valid,
    output rv32i_types::preg_t   wb_tag,
    output rv32i_types::word_t   wb_value
);
    import rv32i_types::*;

    // read stage
    logic               s0_valid;
    preg_t              s0_tag;
    mul_op_t            s0_op;
    // product stage
    logic               a_signed;
    logic               b_signed;
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [63:0] product;
    logic               p1_valid;
    preg_t              p1_tag;
    logic               p1_hi;
    logic [63:0]        p1_prod;

    // mulh treats both as signed, mulhsu only rs1
    always_comb begin
        a_signed = (s0_op == MUL_MULH) || (s0_op == MUL_MULHSU);
        b_signed = (s0_op == MUL_MULH);
        a_ext    = {a_signed & rs1_v[31], rs1_v};
        b_ext    = {b_signed & rs2_v[31], rs2_v};
        product  = a_ext * b_ext;
    end

    // each stage keeps its own valid, one op per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            s0_valid <= 1'b0;
            p1_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s0_valid <= issue_valid;
            p1_valid <= s0_valid;
            wb_valid <= p1_valid;
        end
        s0_tag   <= rd_s;
        s0_op    <= op;
        p1_tag   <= s0_tag;
        p1_hi    <= (s0_op != MUL_MUL);
        p1_prod  <= product;
        wb_tag   <= p1_tag;
        wb_value <= p1_hi ? p1_prod[63:32] : p1_prod[31:0];
    end

endmodule : mul_unit

// File: verilog/physical_regfile.sv
module physical_regfile #(
    parameter int num_regs = rv32i_types::NUM_REGS
) (
    input  logic               clk,
    input  logic               rst,
    // thread context swap from the scheduler
    input  logic               ctx_load,
    input  rv32i_types::word_t ctx_data [rv32i_types::NUM_ARCH_REGS],
    // read tags, two per lane
    input  rv32i_types::preg_t alu_rs1_s,
    input  rv32i_types::preg_t alu_rs2_s,
    input  rv32i_types::preg_t mul_rs1_s,
    input  rv32i_types::preg_t mul_rs2_s,
    input  rv32i_types::preg_t ldst_rs1_s,
    input  rv32i_types::preg_t ldst_rs2_s,
    // write ports, one per lane
    input  logic               alu_we,
    input  logic               mul_we,
    input  logic               ld_we,
    input  rv32i_types::preg_t alu_rd_s,
    input  rv32i_types::preg_t mul_rd_s,
    input  rv32i_types::preg_t ld_rd_s,
    input  rv32i_types::word_t alu_rd_v,
    input  rv32i_types::word_t mul_rd_v,
    input  rv32i_types::word_t ld_rd_v,
    // registered read data
    output rv32i_types::word_t alu_rs1_v,
    output rv32i_types::word_t alu_rs2_v,
    output rv32i_types::word_t mul_rs1_v,
    output rv32i_types::word_t mul_rs2_v,
    output rv32i_types::word_t ldst_rs1_v,
    output rv32i_types::word_t ldst_rs2_v,
    // whole array, for state save and checking
    output rv32i_types::word_t reg_data [num_regs]
);
    import rv32i_types::*;

    word_t regs [num_regs];
    logic  tag_clash;

    // tag 0 is the zero register
    function automatic word_t read_port(input preg_t tag);
        return (tag != '0) ? regs[tag] : '0;
    endfunction

    // later write wins: alu, then mul, then load
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctx_load) begin
            // context swap beats every lane write
            for (int i = 1; i < NUM_ARCH_REGS; i++) begin
                regs[i] <= ctx_data[i];
            end
        end else begin
            if (alu_we && (alu_rd_s != '0)) begin
                regs[alu_rd_s] <= alu_rd_v;
            end
            if (mul_we && (mul_rd_s != '0)) begin
                regs[mul_rd_s] <= mul_rd_v;
            end
            if (ld_we && (ld_rd_s != '0)) begin
                regs[ld_rd_s] <= ld_rd_v;
            end
        end
    end

    // reads see the array before this edge's writes
    always_ff @(posedge clk) begin
        alu_rs1_v  <= read_port(alu_rs1_s);
        alu_rs2_v  <= read_port(alu_rs2_s);
        mul_rs1_v  <= read_port(mul_rs1_s);
        mul_rs2_v  <= read_port(mul_rs2_s);
        ldst_rs1_v <= read_port(ldst_rs1_s);
        ldst_rs2_v <= read_port(ldst_rs2_s);
    end

    assign reg_data = regs;

    // two lanes retiring into one tag means rename handed it out twice
    assign tag_clash =
        (alu_we && mul_we && (alu_rd_s == mul_rd_s) && (alu_rd_s != '0)) ||
        (alu_we && ld_we  && (alu_rd_s == ld_rd_s)  && (alu_rd_s != '0)) ||
        (mul_we && ld_we  && (mul_rd_s == ld_rd_s)  && (mul_rd_s != '0));

    a_no_tag_clash: assert property (@(posedge clk) disable iff (rst) !tag_clash)
        else $error("two write ports hit the same physical tag");

endmodule : physical_regfile

// File: verilog/rv32i_types.sv
package rv32i_types;

    // default physical register count
    localparam int NUM_REGS      = 64;
    // registers in one saved thread context
    localparam int NUM_ARCH_REGS = 32;
    // physical tag width, log2 of the register count
    localparam int PREG_W        = $clog2(NUM_REGS);

    // physical register tag
    typedef logic [PREG_W-1:0] preg_t;
    // data word
    typedef logic [31:0]       word_t;

    // integer alu ops
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // multiply ops, low half or one of the three high halves
    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,
        MUL_MULH   = 2'd1,
        MUL_MULHSU = 2'd2,
        MUL_MULHU  = 2'd3
    } mul_op_t;

    // memory ops, word and byte only
    typedef enum logic [2:0] {
        MEM_LW  = 3'd0,
        MEM_LB  = 3'd1,
        MEM_LBU = 3'd2,
        MEM_SW  = 3'd3,
        MEM_SB  = 3'd4
    } mem_op_t;

endpackage : rv32i_types
